// File: files.f
+incdir+hdl
hdl/mcm_pkg.sv
hdl/prefix_adder.sv
hdl/sm_adder.sv
hdl/mcm_lane.sv
hdl/adder_tree.sv
hdl/req_ack_ctrl.sv
hdl/mcm_dct_top.sv
testbench/tb_mcm_dct_top.sv

// File: hdl/adder_tree.sv
// three-level sign-magnitude adder tree over the lane products, with a registered sum
`default_nettype none
`include "mcm_config.svh"

module adder_tree (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 sum_en_i,
    input  mcm_pkg::sm_word_t [`MCM_LANES-1:0]   products_i,
    output mcm_pkg::sm_word_t                    sum_o
);
    import mcm_pkg::*;

    sm_word_t [`MCM_LANES/2-1:0] lvl1;
    sm_word_t [`MCM_LANES/4-1:0] lvl2;
    sm_word_t                    total;

    // neighbouring lanes first
    for (genvar i = 0; i < `MCM_LANES/2; i++)
    begin : g_lvl1
        sm_adder u_add (.a_i(products_i[2*i]), .b_i(products_i[2*i+1]), .sum_o(lvl1[i]));
    end

    for (genvar i = 0; i < `MCM_LANES/4; i++)
    begin : g_lvl2
        sm_adder u_add (.a_i(lvl1[2*i]), .b_i(lvl1[2*i+1]), .sum_o(lvl2[i]));
    end

    sm_adder u_root (.a_i(lvl2[0]), .b_i(lvl2[1]), .sum_o(total));

    // result holds until the next transaction sums
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            sum_o <= '0;
        else if (sum_en_i)
            sum_o <= total;
    end

endmodule

`default_nettype wire

// File: hdl/mcm_config.svh
// width and lane-count macros for the transform datapath; include before any use
`ifndef MCM_CONFIG_SVH
`define MCM_CONFIG_SVH

// lanes per row with one sample each
`define MCM_LANES 8

// sample magnitude width
`define MCM_IN_W 16

// product and sum magnitude width
`define MCM_ACC_W 32

// coefficient index width for eight constants
`define MCM_CODE_W 3

// clock edges from request capture to ack
`define MCM_LATENCY 3

`endif

// File: hdl/mcm_dct_top.sv
// top level of the integer transform row datapath: controller, eight lanes and adder tree
`default_nettype none
`include "mcm_config.svh"

module mcm_dct_top (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req_i,
    input  mcm_pkg::sm_sample_t [`MCM_LANES-1:0] samples_i,
    input  mcm_pkg::coef_code_t [`MCM_LANES-1:0] codes_i,
    output logic                                 ack_o,
    output mcm_pkg::sm_word_t                    result_o
);
    import mcm_pkg::*;

    logic                        capture;
    logic                        sum_en;
    sm_word_t [`MCM_LANES-1:0]   products;

    req_ack_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .capture_o (capture),
        .sum_en_o  (sum_en),
        .ack_o     (ack_o)
    );

    // one multiplier per sample
    for (genvar i = 0; i < `MCM_LANES; i++)
    begin : g_lane
        mcm_lane u_lane (
            .clk       (clk),
            .rst_n     (rst_n),
            .capture_i (capture),
            .sample_i  (samples_i[i]),
            .code_i    (codes_i[i]),
            .product_o (products[i])
        );
    end

    adder_tree u_tree (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_en_i   (sum_en),
        .products_i (products),
        .sum_o      (result_o)
    );

endmodule

`default_nettype wire

// File: hdl/mcm_lane.sv
// one lane of the shift-add constant multiplier: captures sample and code, registers the product
`default_nettype none
`include "mcm_config.svh"

module mcm_lane (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                capture_i,
    input  mcm_pkg::sm_sample_t sample_i,
    input  mcm_pkg::coef_code_t code_i,
    output mcm_pkg::sm_word_t   product_o
);
    import mcm_pkg::*;

    sm_sample_t            sample_q;
    coef_code_t            code_q;
    logic                  mul_en_q;
    logic [`MCM_ACC_W-1:0] x;
    sm_word_t              x3;
    sm_word_t              x5;
    sm_word_t              x9;
    sm_word_t              x15;
    sm_word_t              x49;
    sm_word_t              x181;
    sm_word_t              x251;
    logic [`MCM_ACC_W-1:0] sel_mag;

    // operands stay put for the whole transaction
    always_ff @(posedge clk)
    begin
        if (capture_i)
        begin
            sample_q <= sample_i;
            code_q   <= code_i;
        end
    end

    // product is written one edge after capture
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mul_en_q <= 1'b0;
        else
            mul_en_q <= capture_i;
    end

    assign x = {{(`MCM_ACC_W - `MCM_IN_W){1'b0}}, sample_q.mag};

    // subexpressions work on magnitudes only, all positive
    sm_adder u_x3 (.a_i({1'b0, x << 1}), .b_i({1'b0, x}), .sum_o(x3));
    sm_adder u_x5 (.a_i({1'b0, x << 2}), .b_i({1'b0, x}), .sum_o(x5));
    sm_adder u_x9 (.a_i({1'b0, x << 3}), .b_i({1'b0, x}), .sum_o(x9));

    // 16x - x
    sm_adder u_x15 (.a_i({1'b0, x << 4}), .b_i({1'b1, x}), .sum_o(x15));

    // 64x - 15x reusing x15
    sm_adder u_x49 (.a_i({1'b0, x << 6}), .b_i({1'b1, x15.mag}), .sum_o(x49));

    // 4 * 49x - 15x
    sm_adder u_x181 (
        .a_i   ({1'b0, x49.mag << 2}),
        .b_i   ({1'b1, x15.mag}),
        .sum_o (x181)
    );

    // 256x - 5x
    sm_adder u_x251 (.a_i({1'b0, x << 8}), .b_i({1'b1, x5.mag}), .sum_o(x251));

    always_comb
    begin
        case (code_q.idx)
            3'd0:    sel_mag = x;
            3'd1:    sel_mag = x3.mag;
            3'd2:    sel_mag = x5.mag;
            3'd3:    sel_mag = x9.mag;
            3'd4:    sel_mag = x15.mag;
            3'd5:    sel_mag = x49.mag;
            3'd6:    sel_mag = x181.mag;
            default: sel_mag = x251.mag;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (mul_en_q)
        begin
            product_o.mag  <= sel_mag;
            // sign is sample xor code, zero stays positive
            product_o.sign <= (sample_q.sign ^ code_q.sign) & (sel_mag != '0);
        end
    end

endmodule

`default_nettype wire

// File: hdl/mcm_pkg.sv
// sign-magnitude types and coefficient table shared by the datapath and its testbench
`default_nettype none
`include "mcm_config.svh"

package mcm_pkg;

    // input sample where sign 1 means negative
    typedef struct packed {
        logic                 sign;
        logic [`MCM_IN_W-1:0] mag;
    } sm_sample_t;

    // products, partial sums and the final result
    typedef struct packed {
        logic                  sign;
        logic [`MCM_ACC_W-1:0] mag;
    } sm_word_t;

    // per-lane coefficient select whose sign bit negates the product
    typedef struct packed {
        logic                   sign;
        logic [`MCM_CODE_W-1:0] idx;
    } coef_code_t;

    localparam int coef_mag_w = 9;

    // constant magnitudes by index
    // each lane builds these from shifts and add/subtract steps
    localparam logic [coef_mag_w-1:0] coef_table [2**`MCM_CODE_W] = '{
        9'd1,
        9'd3,
        9'd5,
        9'd9,
        9'd15,
        9'd49,
        9'd181,
        9'd251
    };

endpackage

`default_nettype wire

// File: hdl/prefix_adder.sv
// kill/generate/propagate prefix adder with recursive-doubling carries, used by sm_adder
`default_nettype none
`include "mcm_config.svh"

module prefix_adder #(
    parameter int WIDTH = `MCM_ACC_W
) (
    input  logic [WIDTH-1:0] a_i,
    input  logic [WIDTH-1:0] b_i,
    input  logic             cin_i,
    output logic [WIDTH-1:0] sum_o,
    output logic             cout_o
);

    localparam int num_levels = $clog2(WIDTH);

    // each position holds {both, either} as 00 kill, 01 propagate or 11 generate
    // position 0 holds the carry in, position i+1 belongs to bit i
    logic [1:0]       kgp [num_levels+1][WIDTH+1];
    logic [WIDTH-1:0] carry;

    // upper span wins unless it only propagates
    function automatic logic [1:0] kgp_merge(input logic [1:0] lo, input logic [1:0] hi);
        logic [1:0] res;
        if (hi[1] == hi[0])
            res = hi;
        else
            res = lo;
        return res;
    endfunction

    assign kgp[0][0] = {cin_i, cin_i};

    for (genvar i = 0; i < WIDTH; i++)
    begin : g_bit
        assign kgp[0][i+1] = {a_i[i] & b_i[i], a_i[i] | b_i[i]};
    end

    // level l looks 2**l positions down
    for (genvar l = 0; l < num_levels; l++)
    begin : g_level
        for (genvar p = 0; p <= WIDTH; p++)
        begin : g_pos
            if (p < (1 << l))
            begin : g_pass
                assign kgp[l+1][p] = kgp[l][p];
            end
            else
            begin : g_merge
                assign kgp[l+1][p] = kgp_merge(kgp[l][p - (1 << l)], kgp[l][p]);
            end
        end
    end

    // every position below WIDTH is now kill or generate
    for (genvar i = 0; i < WIDTH; i++)
    begin : g_sum
        assign carry[i] = kgp[num_levels][i][1];
        assign sum_o[i] = a_i[i] ^ b_i[i] ^ carry[i];
    end

    // top bit decides unless it propagates the carry into it
    assign cout_o = (kgp[0][WIDTH][1] == kgp[0][WIDTH][0]) ? kgp[0][WIDTH][1]
                                                            : carry[WIDTH-1];

endmodule

`default_nettype wire

// File: hdl/req_ack_ctrl.sv
// four-phase req/ack controller that sequences capture, multiply and sum for the datapath
`default_nettype none

module req_ack_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic req_i,
    output logic capture_o,
    output logic sum_en_o,
    output logic ack_o
);

    typedef enum logic [2:0] {
        st_idle,
        st_capture,
        st_multiply,
        st_sum,
        st_hold,
        st_release
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_idle:
                if (req_i)
                    state_d = st_capture;
            st_capture:  state_d = st_multiply;
            st_multiply: state_d = st_sum;
            st_sum:      state_d = st_hold;
            // wait for the requester to drop req
            st_hold:
                if (!req_i)
                    state_d = st_release;
            // ack is low here, a new request may already be up
            st_release:  state_d = req_i ? st_capture : st_idle;
            default:     state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= st_idle;
        else
            state_q <= state_d;
    end

    // outputs decode straight from the state register
    assign capture_o = (state_q == st_capture);
    assign sum_en_o  = (state_q == st_sum);
    assign ack_o     = (state_q == st_hold);

endmodule

`default_nettype wire

// File: hdl/sm_adder.sv
// combinational sign-magnitude adder for lane subexpressions and the adder tree
`default_nettype none
`include "mcm_config.svh"

module sm_adder (
    input  mcm_pkg::sm_word_t a_i,
    input  mcm_pkg::sm_word_t b_i,
    output mcm_pkg::sm_word_t sum_o
);

    logic                  same_sign;
    logic [`MCM_ACC_W-1:0] b_operand;
    logic [`MCM_ACC_W-1:0] raw_sum;
    logic                  raw_cout;
    logic [`MCM_ACC_W-1:0] neg_sum;
    logic [`MCM_ACC_W-1:0] res_mag;
    logic                  res_sign;

    assign same_sign = (a_i.sign == b_i.sign);

    // unequal signs subtract as a + ~b + 1
    assign b_operand = same_sign ? b_i.mag : ~b_i.mag;

    prefix_adder #(
        .WIDTH (`MCM_ACC_W)
    ) u_add (
        .a_i    (a_i.mag),
        .b_i    (b_operand),
        .cin_i  (~same_sign),
        .sum_o  (raw_sum),
        .cout_o (raw_cout)
    );

    // no carry out means b was larger, so negate the difference
    prefix_adder #(
        .WIDTH (`MCM_ACC_W)
    ) u_recomp (
        .a_i    (~raw_sum),
        .b_i    ('0),
        .cin_i  (1'b1),
        .sum_o  (neg_sum),
        .cout_o ()
    );

    always_comb
    begin
        if (same_sign || raw_cout)
        begin
            res_mag  = raw_sum;
            res_sign = a_i.sign;
        end
        else
        begin
            res_mag  = neg_sum;
            res_sign = b_i.sign;
        end
    end

    // zero is always positive
    assign sum_o.sign = res_sign & (res_mag != '0);
    assign sum_o.mag  = res_mag;

endmodule

`default_nettype wire

// File: testbench/tb_mcm_dct_top.sv
// directed testbench for the transform datapath top level; compile with files.f and run tb_mcm_dct_top
`default_nettype none
`include "mcm_config.svh"

module tb_mcm_dct_top;
    timeunit 1ns;
    timeprecision 100ps;
    import mcm_pkg::*;

    typedef sm_sample_t [`MCM_LANES-1:0] sample_row_t;
    typedef coef_code_t [`MCM_LANES-1:0] code_row_t;

    localparam int clk_period       = 20;
    localparam int cycles_per_txn   = 8;
    // handshake, coefficient table, cancellation, random rows, maximum
    localparam int num_transactions = 2 + 8 * 8 * 4 + 6 + 60 + 2;

    logic        clk;
    logic        rst_n;
    logic        req_i;
    sample_row_t samples;
    code_row_t   codes;
    logic        ack;
    sm_word_t    result;

    int          check_count = 0;
    int          error_count = 0;
    logic [31:0] lcg_state   = 32'h0674ca1b;

    mcm_dct_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .samples_i (samples),
        .codes_i   (codes),
        .ack_o     (ack),
        .result_o  (result)
    );

    initial
        clk = 1'b0;

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // signed sum of sample times table constant over all lanes
    function automatic sm_word_t model_row(input sample_row_t s, input code_row_t c);
        longint   total;
        longint   term;
        sm_word_t res;
        total = 0;
        for (int i = 0; i < `MCM_LANES; i++)
        begin
            term = longint'(s[i].mag) * longint'(coef_table[c[i].idx]);
            if (s[i].sign ^ c[i].sign)
                total = total - term;
            else
                total = total + term;
        end
        res.sign = (total < 0);
        res.mag  = (total < 0) ? 32'(-total) : 32'(total);
        return res;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("%-14s done, %0d mismatches", name, error_count - errs_before);
    endtask

    // called at a falling edge, returns at a falling edge with ack low
    task automatic do_transaction(input string name, input sample_row_t s, input code_row_t c,
                                  input int hold_cycles, output sm_word_t res,
                                  output int latency, output int release_cycles);
        int n;
        samples = s;
        codes   = c;
        req_i   = 1'b1;
        n       = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!ack);
        // first edge after raising req is edge 0
        latency = n - 1;
        res     = result;
        repeat (hold_cycles)
        begin
            @(negedge clk);
            check({name, " ack held"}, 1, ack);
            check({name, " result held"}, res, result);
        end
        req_i = 1'b0;
        n     = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (ack);
        release_cycles = n;
    endtask

    task automatic run_row(input string name, input sample_row_t s, input code_row_t c);
        sm_word_t res;
        int       lat;
        int       rel;
        do_transaction(name, s, c, 0, res, lat, rel);
        check(name, model_row(s, c), res);
    endtask

    task automatic test_reset();
        int errs;
        errs  = error_count;
        rst_n = 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check("reset ack", 0, ack);
            check("reset result", 0, result);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check("after reset ack", 0, ack);
        check("after reset result", 0, result);
        report_test("reset", errs);
    endtask

    task automatic test_handshake();
        sample_row_t s;
        code_row_t   c;
        sm_word_t    res;
        int          lat;
        int          rel;
        int          errs;
        errs = error_count;
        for (int i = 0; i < `MCM_LANES; i++)
        begin
            s[i] = '{sign: i[0], mag: 16'(100 * i + 7)};
            c[i] = '{sign: 1'b0, idx: 3'(i)};
        end
        do_transaction("handshake", s, c, 6, res, lat, rel);
        check("handshake latency", `MCM_LATENCY, lat);
        check("handshake release", 1, rel);
        check("handshake result", model_row(s, c), res);
        // second request raised as soon as ack is low
        s[3].sign = ~s[3].sign;
        do_transaction("back to back", s, c, 0, res, lat, rel);
        check("back to back latency", `MCM_LATENCY, lat);
        check("back to back release", 1, rel);
        check("back to back result", model_row(s, c), res);
        report_test("handshake", errs);
    endtask

    task automatic test_coef_table();
        sample_row_t s;
        code_row_t   c;
        int          errs;
        errs = error_count;
        for (int lane = 0; lane < `MCM_LANES; lane++)
            for (int idx = 0; idx < 8; idx++)
                for (int sgn = 0; sgn < 4; sgn++)
                begin
                    s = '0;
                    c = '0;
                    // odd magnitude so the sign of the product is always visible
                    s[lane].mag  = 16'(next_random() >> 16) | 16'd1;
                    s[lane].sign = sgn[0];
                    c[lane].idx  = 3'(idx);
                    c[lane].sign = sgn[1];
                    run_row($sformatf("coef lane %0d idx %0d sgn %0d", lane, idx, sgn), s, c);
                end
        report_test("coef table", errs);
    endtask

    task automatic test_cancellation();
        sample_row_t s;
        code_row_t   c;
        sm_word_t    res;
        int          lat;
        int          rel;
        int          errs;
        errs = error_count;
        // equal lanes with opposite sample signs
        for (int p = 0; p < `MCM_LANES / 2; p++)
        begin
            s = '0;
            c = '0;
            s[2*p]   = '{sign: 1'b0, mag: 16'(1234 + p)};
            s[2*p+1] = '{sign: 1'b1, mag: 16'(1234 + p)};
            c[2*p]   = '{sign: 1'b0, idx: 3'(2 * p + 1)};
            c[2*p+1] = '{sign: 1'b0, idx: 3'(2 * p + 1)};
            do_transaction("cancel pair", s, c, 0, res, lat, rel);
            check("cancel pair", {1'b0, 32'd0}, res);
        end
        // 5 * 3 cancels 3 * 5 through a negative code
        s = '0;
        c = '0;
        s[1] = '{sign: 1'b0, mag: 16'd5};
        c[1] = '{sign: 1'b0, idx: 3'd1};
        s[6] = '{sign: 1'b0, mag: 16'd3};
        c[6] = '{sign: 1'b1, idx: 3'd2};
        do_transaction("cancel cross", s, c, 0, res, lat, rel);
        check("cancel cross", {1'b0, 32'd0}, res);
        // 900 - 2510 + 343
        s = '0;
        c = '0;
        s[0] = '{sign: 1'b0, mag: 16'd100};
        c[0] = '{sign: 1'b0, idx: 3'd3};
        s[4] = '{sign: 1'b1, mag: 16'd10};
        c[4] = '{sign: 1'b0, idx: 3'd7};
        s[7] = '{sign: 1'b1, mag: 16'd7};
        c[7] = '{sign: 1'b1, idx: 3'd5};
        do_transaction("mixed negative", s, c, 0, res, lat, rel);
        check("mixed negative", {1'b1, 32'd1267}, res);
        report_test("cancellation", errs);
    endtask

    task automatic test_random();
        sample_row_t s;
        code_row_t   c;
        logic [31:0] r;
        int          errs;
        errs = error_count;
        for (int row = 0; row < 60; row++)
        begin
            for (int i = 0; i < `MCM_LANES; i++)
            begin
                r    = next_random();
                s[i] = '{sign: r[15], mag: r[31:16]};
                c[i] = '{sign: r[11], idx: r[14:12]};
            end
            run_row($sformatf("random row %0d", row), s, c);
        end
        report_test("random rows", errs);
    endtask

    task automatic test_maximum();
        sample_row_t s;
        code_row_t   c;
        sm_word_t    res;
        int          lat;
        int          rel;
        int          errs;
        errs = error_count;
        for (int neg = 0; neg < 2; neg++)
        begin
            for (int i = 0; i < `MCM_LANES; i++)
            begin
                s[i] = '{sign: neg[0], mag: 16'hffff};
                c[i] = '{sign: 1'b0, idx: 3'd7};
            end
            do_transaction("maximum", s, c, 0, res, lat, rel);
            check("maximum", {neg[0], 32'(65535 * 251 * `MCM_LANES)}, res);
        end
        report_test("maximum", errs);
    endtask

    initial
    begin
        rst_n   = 1'b0;
        req_i   = 1'b0;
        samples = '0;
        codes   = '0;
        test_reset();
        test_handshake();
        test_coef_table();
        test_cancellation();
        test_random();
        test_maximum();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // bound on the whole run from the number of transactions
    initial
    begin
        #((num_transactions * cycles_per_txn + 200) * clk_period);
        $display("watchdog expired, the DUT did not finish the handshakes in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
